// ==== files.f ====
rtl/bridgePkg.sv
rtl/transferClassifier.sv
rtl/cycleSequencer.sv
rtl/dataLaneRouter.sv
rtl/busBridgeTop.sv
dv/busBridge_assertions.sv
dv/busBridgeTb.sv

// ==== dv/bridge_testdata.txt ====
# rnw portSize siz a040 cpuData amigaData0 amigaData1 starts addr0 addr1 expRead expWrite0 expWrite1
# hex fields, data words with the UU lane first, expWrite1 and addr1 only used when starts is 2
1 1 2 0 00000000 11223344 00000000 1 0 0 11223344 00000000 00000000
0 1 1 1 A1B2C3D4 00000000 00000000 1 1 0 00000000 A1B2C3D4 00000000
1 1 2 2 00000000 55667788 00000000 1 2 0 55665566 00000000 00000000
0 1 2 2 99AABBCC 00000000 00000000 1 2 0 00000000 BBCCBBCC 00000000
1 1 1 3 00000000 DEADBEEF 00000000 1 3 0 DEADDEAD 00000000 00000000
1 1 1 0 00000000 8899AABB 00000000 1 0 0 8899AABB 00000000 00000000
0 1 1 2 00112233 00000000 00000000 1 2 0 00000000 22332233 00000000
1 1 0 0 00000000 1234ABCD 5678EF01 2 0 2 12345678 00000000 00000000
0 1 0 0 CAFEF00D 00000000 00000000 2 0 2 00000000 CAFEF00D F00DF00D
1 1 3 0 00000000 2468ACE0 13571357 2 0 2 24681357 00000000 00000000
0 1 0 0 01234567 00000000 00000000 2 0 2 00000000 01234567 45674567
1 0 0 0 00000000 0BADC0DE 00000000 1 0 0 0BADC0DE 00000000 00000000
0 0 0 0 13579BDF 00000000 00000000 1 0 0 00000000 13579BDF 00000000
1 0 2 0 00000000 76543210 00000000 1 0 0 76543210 00000000 00000000

// ==== dv/busBridgeTb.sv ====
module busBridgeTb;

    logic CLK80, CLK40, RESETn, TS_CPUn, RnW, PORTSIZE, TACKn;
    logic TAn, TBI_CPUn, TCI_CPUn, TSn;
    bridgePkg::transferSize_t SIZ;
    bridgePkg::addrLow_t A_040, A_AMIGA;
    wire bridgePkg::byteLane_t dUu040, dUm040, dLm040, dLl040;
    wire bridgePkg::byteLane_t dUuAmiga, dUmAmiga, dLmAmiga, dLlAmiga;
    logic cpuDrive, amigaDrive;
    logic [31:0] cpuOut, amigaOut, readData, curAmiga0, curAmiga1;
    // One row per transfer, columns as in the data file
    logic [31:0] vec [0:31][0:12];
    int numTests = 0;
    bit dataLoaded = 1'b0;
    int startCount, ackCount, taCount;
    bridgePkg::addrLow_t seenAddr [2];
    logic [31:0] seenWrite [2];
    integer seed = 32'h3efb92d3;

    // Each side drives its lanes only when it is the source
    assign {dUu040, dUm040, dLm040, dLl040} = cpuDrive ? cpuOut : 'z;
    assign {dUuAmiga, dUmAmiga, dLmAmiga, dLlAmiga} = amigaDrive ? amigaOut : 'z;

    busBridgeTop dut (
        .CLK80 (CLK80), .CLK40 (CLK40), .TS_CPUn (TS_CPUn), .RESETn (RESETn),
        .RnW (RnW), .PORTSIZE (PORTSIZE), .TACKn (TACKn), .SIZ (SIZ), .A_040 (A_040),
        .TAn (TAn), .TBI_CPUn (TBI_CPUn), .TCI_CPUn (TCI_CPUn), .A_AMIGA (A_AMIGA),
        .TSn (TSn), .D_UU_040 (dUu040), .D_UM_040 (dUm040), .D_LM_040 (dLm040),
        .D_LL_040 (dLl040), .D_UU_AMIGA (dUuAmiga), .D_UM_AMIGA (dUmAmiga),
        .D_LM_AMIGA (dLmAmiga), .D_LL_AMIGA (dLlAmiga)
    );

    //////////////////////////////
    // Clocks and event counters
    //////////////////////////////

    always #2 CLK80 = ~CLK80;
    always @(posedge CLK80) CLK40 <= ~CLK40;
    always @(negedge TSn) if (RESETn) startCount++;
    always @(negedge TAn) if (RESETn) taCount++;

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic failRun(string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkLane(string testName, bridgePkg::byteLane_t expected, actual);
        if (actual !== expected)
            failRun($sformatf("[ERROR] %s: expected %h, actual %h", testName, expected, actual));
    endtask

    task automatic checkAddr(string testName, bridgePkg::addrLow_t expected, actual);
        if (actual !== expected)
            failRun($sformatf("[ERROR] %s: expected %h, actual %h", testName, expected, actual));
    endtask

    task automatic checkCount(string testName, int expected, int actual);
        if (actual != expected)
            failRun($sformatf("[ERROR] %s: expected %0d, actual %0d", testName, expected, actual));
    endtask

    task automatic checkLevel(string testName, logic expected, logic actual);
        if (actual !== expected)
            failRun($sformatf("[ERROR] %s: expected %b, actual %b", testName, expected, actual));
    endtask

    // UU lane sits in the top byte
    task automatic checkWord(string testName, logic [31:0] expected, logic [31:0] actual);
        for (int l = 0; l < 4; l++)
            checkLane($sformatf("%s lane %0d", testName, l), expected[31 - 8 * l -: 8],
                actual[31 - 8 * l -: 8]);
    endtask

    //////////////////////////////
    // Amiga port model
    //////////////////////////////

    // Answers each TSn once it ends, after 1 to 4 random cycles
    initial begin : amigaPort
        int waitCycles;
        forever begin
            @(negedge CLK80);
            if (RESETn && !TSn) begin
                // Read data goes out just after the next rising edge
                @(posedge CLK80);
                #1 amigaOut = (ackCount == 0) ? curAmiga0 : curAmiga1;
                amigaDrive = RnW;
                while (!TSn) @(negedge CLK80);
                waitCycles = 1 + ($unsigned($random(seed)) % 4);
                repeat (waitCycles) @(posedge CLK80);
                #1 TACKn = 1'b0;
                if (ackCount < 2) begin
                    seenAddr[ackCount] = A_AMIGA;
                    seenWrite[ackCount] = {dUuAmiga, dUmAmiga, dLmAmiga, dLlAmiga};
                end
                ackCount++;
                @(posedge CLK80);
                #1 TACKn = 1'b1;
                amigaDrive = 1'b0;
            end
        end
    end

    // Budget of 200 time units per transfer
    initial begin
        wait (dataLoaded);
        #(numTests * 200);
        failRun("Run timed out, a transfer never finished");
    end

    //////////////////////////////
    // CPU driver
    //////////////////////////////

    initial begin
        int fd;
        string line;
        string name;
        {CLK80, CLK40, RESETn, TS_CPUn, RnW, PORTSIZE, TACKn} = 7'b0001111;
        SIZ = '0;
        A_040 = '0;
        {cpuDrive, amigaDrive, cpuOut, amigaOut, curAmiga0, curAmiga1} = '0;
        {startCount, ackCount, taCount} = '0;
        fd = $fopen("dv/bridge_testdata.txt", "r");
        if (fd == 0) failRun("Could not open dv/bridge_testdata.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                    vec[numTests][0], vec[numTests][1], vec[numTests][2], vec[numTests][3],
                    vec[numTests][4], vec[numTests][5], vec[numTests][6], vec[numTests][7],
                    vec[numTests][8], vec[numTests][9], vec[numTests][10], vec[numTests][11],
                    vec[numTests][12]) != 13)
                    failRun("Malformed line in the test data file");
                numTests++;
            end
        end
        $fclose(fd);
        if (numTests == 0) failRun("Test data file holds no transfers");
        dataLoaded = 1'b1;

        repeat (8) @(posedge CLK80);
        #1 RESETn = 1'b1;
        // Idle levels after reset, default parameters
        @(posedge CLK80);
        #1 checkLevel("reset TSn", 1'b1, TSn);
        checkLevel("reset TBI_CPUn", 1'b0, TBI_CPUn);
        checkLevel("reset TCI_CPUn", 1'b0, TCI_CPUn);
        TACKn = 1'b0;
        #1 checkLevel("idle TAn low", 1'b0, TAn);
        TACKn = 1'b1;
        #1 checkLevel("idle TAn high", 1'b1, TAn);

        for (int i = 0; i < numTests; i++) begin
            name = $sformatf("transfer %0d", i);
            @(posedge CLK80);
            #1 RnW = vec[i][0][0];
            PORTSIZE = vec[i][1][0];
            SIZ = vec[i][2][1:0];
            A_040 = vec[i][3][1:0];
            cpuOut = vec[i][4];
            cpuDrive = !vec[i][0][0];
            curAmiga0 = vec[i][5];
            curAmiga1 = vec[i][6];
            {startCount, ackCount, taCount} = '0;
            // One CLK40 period of CPU start, so one CLK80 fall sees CLK40 high
            TS_CPUn = 1'b0;
            repeat (2) @(posedge CLK80);
            #1 TS_CPUn = 1'b1;
            @(negedge TAn);
            readData = {dUu040, dUm040, dLm040, dLl040};
            repeat (8) @(posedge CLK80);
            checkCount({name, " starts"}, vec[i][7], startCount);
            checkCount({name, " acks"}, vec[i][7], ackCount);
            checkCount({name, " TAn"}, 1, taCount);
            checkAddr({name, " addr0"}, vec[i][8][1:0], seenAddr[0]);
            if (vec[i][7] == 2) checkAddr({name, " addr1"}, vec[i][9][1:0], seenAddr[1]);
            if (vec[i][0][0]) begin
                checkWord({name, " read"}, vec[i][10], readData);
            end else begin
                checkWord({name, " write0"}, vec[i][11], seenWrite[0]);
                if (vec[i][7] == 2) checkWord({name, " write1"}, vec[i][12], seenWrite[1]);
            end
            #1 cpuDrive = 1'b0;
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== dv/busBridge_assertions.sv ====
module sequencerAssertions (
    input logic                   CLK80,
    input logic                   CLK40,
    input logic                   RESETn,
    input logic                   TSn,
    input logic                   TAn,
    input logic                   captureUpper,
    input logic                   longWordCycle,
    input bridgePkg::cycleState_t cycleState
);

    // CPU must not see an acknowledge for the upper word
    assert property (@(negedge CLK80) disable iff (!RESETn)
        (cycleState == bridgePkg::firstWord) |-> TAn)
        else $error("TAn low during firstWord");

    // Any CLK40 fall inside reset leaves TSn high
    assert property (@(negedge CLK40) !RESETn |=> TSn)
        else $error("TSn not high during reset");

    // Latch strobe is a single CLK80 cycle
    assert property (@(negedge CLK80) disable iff (!RESETn)
        captureUpper |=> !captureUpper)
        else $error("captureUpper longer than one cycle");

    // Split cycle must finish, slow ports included
    assert property (@(negedge CLK80) disable iff (!RESETn)
        $rose(longWordCycle) |-> ##[1:100] (cycleState == bridgePkg::idle))
        else $error("split cycle did not return to idle");

endmodule

bind cycleSequencer sequencerAssertions seqChecks (
    .CLK80         (CLK80),
    .CLK40         (CLK40),
    .RESETn        (RESETn),
    .TSn           (TSn),
    .TAn           (TAn),
    .captureUpper  (captureUpper),
    .longWordCycle (longWordCycle),
    .cycleState    (cycleState)
);

// ==== rtl/busBridgeTop.sv ====
module busBridgeTop #(
    parameter bit BURST_INHIBIT = 1'b1,
    parameter bit CACHE_INHIBIT = 1'b1
) (
    input  logic                      CLK80,
    input  logic                      CLK40,
    input  logic                      TS_CPUn,
    input  logic                      RESETn,
    input  logic                      RnW,
    input  logic                      PORTSIZE,
    input  logic                      TACKn,
    input  bridgePkg::transferSize_t  SIZ,
    input  bridgePkg::addrLow_t       A_040,
    output logic                      TAn,
    output logic                      TBI_CPUn,
    output logic                      TCI_CPUn,
    output bridgePkg::addrLow_t       A_AMIGA,
    output logic                      TSn,
    // 68040 data bus
    inout  wire bridgePkg::byteLane_t D_UU_040,
    inout  wire bridgePkg::byteLane_t D_UM_040,
    inout  wire bridgePkg::byteLane_t D_LM_040,
    inout  wire bridgePkg::byteLane_t D_LL_040,
    // Amiga data bus
    inout  wire bridgePkg::byteLane_t D_UU_AMIGA,
    inout  wire bridgePkg::byteLane_t D_UM_AMIGA,
    inout  wire bridgePkg::byteLane_t D_LM_AMIGA,
    inout  wire bridgePkg::byteLane_t D_LL_AMIGA
);

    // Split control shared by the three blocks
    logic longWordStart;
    logic flip;
    logic longWordCycle;
    logic addrOut;
    logic captureUpper;

    //////////////////////////////
    // Classifier and sequencer
    //////////////////////////////

    transferClassifier classifier (
        .CLK80            (CLK80),
        .RESETn           (RESETn),
        .TSn              (TSn),
        .PORTSIZE         (PORTSIZE),
        .SIZ              (SIZ),
        .A_AMIGA          (A_AMIGA),
        .longWordCycle    (longWordCycle),
        .longWordTransfer (),
        .longWordStart    (longWordStart),
        .flip             (flip)
    );

    cycleSequencer #(
        .BURST_INHIBIT (BURST_INHIBIT),
        .CACHE_INHIBIT (CACHE_INHIBIT)
    ) sequencer (
        .CLK80         (CLK80),
        .CLK40         (CLK40),
        .RESETn        (RESETn),
        .TS_CPUn       (TS_CPUn),
        .TACKn         (TACKn),
        .longWordStart (longWordStart),
        .TSn           (TSn),
        .TAn           (TAn),
        .TBI_CPUn      (TBI_CPUn),
        .TCI_CPUn      (TCI_CPUn),
        .longWordCycle (longWordCycle),
        .addrOut       (addrOut),
        .captureUpper  (captureUpper)
    );

    //////////////////////////////
    // Data lanes
    //////////////////////////////

    dataLaneRouter router (
        .CLK80         (CLK80),
        .RESETn        (RESETn),
        .RnW           (RnW),
        .A_040         (A_040),
        .longWordCycle (longWordCycle),
        .addrOut       (addrOut),
        .captureUpper  (captureUpper),
        .flip          (flip),
        .A_AMIGA       (A_AMIGA),
        .D_UU_040      (D_UU_040),
        .D_UM_040      (D_UM_040),
        .D_LM_040      (D_LM_040),
        .D_LL_040      (D_LL_040),
        .D_UU_AMIGA    (D_UU_AMIGA),
        .D_UM_AMIGA    (D_UM_AMIGA),
        .D_LM_AMIGA    (D_LM_AMIGA),
        .D_LL_AMIGA    (D_LL_AMIGA)
    );

endmodule

// ==== rtl/dataLaneRouter.sv ====
module dataLaneRouter (
    input  logic                  CLK80,
    input  logic                  RESETn,
    input  logic                  RnW,
    input  bridgePkg::addrLow_t   A_040,
    input  logic                  longWordCycle,
    input  logic                  addrOut,
    input  logic                  captureUpper,
    input  logic                  flip,
    output bridgePkg::addrLow_t   A_AMIGA,
    inout  wire bridgePkg::byteLane_t D_UU_040,
    inout  wire bridgePkg::byteLane_t D_UM_040,
    inout  wire bridgePkg::byteLane_t D_LM_040,
    inout  wire bridgePkg::byteLane_t D_LL_040,
    inout  wire bridgePkg::byteLane_t D_UU_AMIGA,
    inout  wire bridgePkg::byteLane_t D_UM_AMIGA,
    inout  wire bridgePkg::byteLane_t D_LM_AMIGA,
    inout  wire bridgePkg::byteLane_t D_LL_AMIGA
);

    // Upper word of a split read, held for the CPU
    bridgePkg::byteLane_t latchedUu;
    bridgePkg::byteLane_t latchedUm;

    //////////////////////////////
    // Amiga address
    //////////////////////////////

    // Split cycles are always aligned, so bit 0 stays clear
    assign A_AMIGA = longWordCycle ? {addrOut, 1'b0} : A_040;

    //////////////////////////////
    // Read latch
    //////////////////////////////

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            latchedUu <= '0;
            latchedUm <= '0;
        end else if (captureUpper && RnW) begin
            latchedUu <= D_UU_AMIGA;
            latchedUm <= D_UM_AMIGA;
        end
    end

    //////////////////////////////
    // Lane steering
    //////////////////////////////

    // Reads, Amiga to CPU
    // Split read shows the held high word on the CPU upper lanes
    assign D_UU_040 = !RnW ? 'z : (longWordCycle ? latchedUu : D_UU_AMIGA);
    assign D_UM_040 = !RnW ? 'z : (longWordCycle ? latchedUm : D_UM_AMIGA);
    // Word port data arrives on the Amiga upper lanes
    // so offset 2 swaps it down to the CPU lower lanes
    assign D_LM_040 = !RnW ? 'z : (flip ? D_UU_AMIGA : D_LM_AMIGA);
    assign D_LL_040 = !RnW ? 'z : (flip ? D_UM_AMIGA : D_LL_AMIGA);

    // Writes, CPU to Amiga
    // same swap the other way round
    assign D_UU_AMIGA = RnW ? 'z : (flip ? D_LM_040 : D_UU_040);
    assign D_UM_AMIGA = RnW ? 'z : (flip ? D_LL_040 : D_UM_040);
    // Lower Amiga lanes never swap
    assign D_LM_AMIGA = RnW ? 'z : D_LM_040;
    assign D_LL_AMIGA = RnW ? 'z : D_LL_040;

endmodule

// ==== rtl/cycleSequencer.sv ====
module cycleSequencer #(
    parameter bit BURST_INHIBIT = 1'b1,
    parameter bit CACHE_INHIBIT = 1'b1
) (
    input  logic CLK80,
    input  logic CLK40,
    input  logic RESETn,
    input  logic TS_CPUn,
    input  logic TACKn,
    input  logic longWordStart,
    output logic TSn,
    output logic TAn,
    output logic TBI_CPUn,
    output logic TCI_CPUn,
    output logic longWordCycle,
    output logic addrOut,
    output logic captureUpper
);

    // Request for one Amiga start, sampled on CLK40
    logic tsEnable;
    // Acknowledge pass-through enable
    logic taEnable;
    bridgePkg::cycleState_t cycleState;

    //////////////////////////////
    // Transfer start
    //////////////////////////////

    // TSn lives in the CLK40 domain
    // A request seen on one fall gives one CLK40 period of TSn low
    always_ff @(negedge CLK40) begin
        if (!RESETn) begin
            TSn <= 1'b1;
        end else begin
            TSn <= ~tsEnable;
        end
    end

    //////////////////////////////
    // Cycle termination
    //////////////////////////////

    // Acknowledge goes to the CPU only when enabled
    // Also blocked on the cycle where the split is being recognised
    assign TAn = (taEnable && !longWordStart) ? TACKn : 1'b1;

    // Fixed inhibit levels, active low at the CPU
    assign TBI_CPUn = ~BURST_INHIBIT;
    assign TCI_CPUn = ~CACHE_INHIBIT;

    // Router latches the upper lanes on the first word's acknowledge
    assign captureUpper = (cycleState == bridgePkg::firstWord) && !TACKn;

    //////////////////////////////
    // Split cycle FSM
    //////////////////////////////

    // One CPU long word into a word port becomes two local word cycles
    // High word at offset 0 first, low word at offset 2 second
    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            tsEnable      <= 1'b0;
            taEnable      <= 1'b1;
            longWordCycle <= 1'b0;
            addrOut       <= 1'b0;
            cycleState    <= bridgePkg::idle;
        end else begin
            case (cycleState)
                bridgePkg::idle: begin
                    if (longWordStart) begin
                        // Take the cycle over from the CPU
                        tsEnable      <= 1'b0;
                        taEnable      <= 1'b0;
                        longWordCycle <= 1'b1;
                        addrOut       <= 1'b0;
                        cycleState    <= bridgePkg::firstWord;
                    end else begin
                        // CPU start with CLK40 high, so the next CLK40 fall sees it
                        tsEnable <= !TS_CPUn && CLK40;
                    end
                end

                bridgePkg::firstWord: begin
                    // Slow ports simply stretch this state
                    if (!TACKn) begin
                        cycleState <= bridgePkg::secondStart;
                    end
                end

                bridgePkg::secondStart: begin
                    // Point the Amiga at the low word
                    addrOut <= 1'b1;
                    // Same CLK40 phase rule as a CPU start
                    if (CLK40) begin
                        tsEnable   <= 1'b1;
                        taEnable   <= 1'b1;
                        cycleState <= bridgePkg::secondWord;
                    end
                end

                bridgePkg::secondWord: begin
                    // One pulse only
                    tsEnable <= 1'b0;
                    // This acknowledge also ends the CPU cycle
                    if (!TACKn) begin
                        longWordCycle <= 1'b0;
                        addrOut       <= 1'b0;
                        cycleState    <= bridgePkg::idle;
                    end
                end

                default: begin
                    cycleState <= bridgePkg::idle;
                end
            endcase
        end
    end

endmodule

// ==== rtl/transferClassifier.sv ====
module transferClassifier (
    input  logic                      CLK80,
    input  logic                      RESETn,
    input  logic                      TSn,
    input  logic                      PORTSIZE,
    input  bridgePkg::transferSize_t  SIZ,
    input  bridgePkg::addrLow_t       A_AMIGA,
    input  logic                      longWordCycle,
    output logic                      longWordTransfer,
    output logic                      longWordStart,
    output logic                      flip
);

    // SIZ codes that move a whole long word
    localparam bridgePkg::transferSize_t SIZE_LONG = 2'b00;
    localparam bridgePkg::transferSize_t SIZE_LINE = 2'b11;

    // TSn as seen on the previous CLK80 fall
    logic tsnLast;

    //////////////////////////////
    // Size decode
    //////////////////////////////

    // Long and line sizes count as long words
    // A long port (PORTSIZE low) also takes the long word path
    assign longWordTransfer = (SIZ == SIZE_LONG) || (SIZ == SIZE_LINE) || !PORTSIZE;

    // Byte or word at offset 2 goes on the upper lanes of a word port
    // During a split cycle only the second word has A_AMIGA[1] set
    assign flip = (!longWordTransfer || longWordCycle) && A_AMIGA[1];

    //////////////////////////////
    // Split start flag
    //////////////////////////////

    always_ff @(negedge CLK80) begin
        if (!RESETn) begin
            tsnLast       <= 1'b1;
            longWordStart <= 1'b0;
        end else begin
            tsnLast <= TSn;
            // First fall with TSn low, long word into a word port
            // The local start of the second word is ignored
            longWordStart <= tsnLast && !TSn && PORTSIZE && longWordTransfer
                && !longWordCycle;
        end
    end

endmodule

// ==== rtl/bridgePkg.sv ====
package bridgePkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////

    // One 8-bit lane of either data bus
    typedef logic [7:0] byteLane_t;

    // Address bits 1..0, enough to pick a byte within a long word
    typedef logic [1:0] addrLow_t;

    // 68040 SIZ code
    // 00 long word, 01 byte, 10 word, 11 line
    typedef logic [1:0] transferSize_t;

    //////////////////////////////
    // Split cycle sequencer
    //////////////////////////////

    // Idle passes plain cycles straight through
    // FirstWord waits for the Amiga to take the upper word
    // SecondStart issues the local start for the lower word
    // SecondWord waits for the last acknowledge
    typedef enum logic [1:0] {
        idle,
        firstWord,
        secondStart,
        secondWord
    } cycleState_t;

endpackage
